//--- filelist.f
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/decode_latch.sv
verilog/instr_classifier.sv
verilog/imm_gen.sv
verilog/exec_ctrl_gen.sv
verilog/rv_decode.sv
verification/rv_decode_assertions.sv
verification/tb_rv_decode.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run the testbench and scan the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_rv_decode \
    -o tb_rv_decode \
    && ./obj_dir/tb_rv_decode > sim.log 2>&1

grep -qx "all tests passed" sim.log \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED, see sim.log"; exit 1; }

//--- verification/rv_decode_assertions.sv
`timescale 1ns/1ps

module rv_decode_assertions
(
    input logic                      i_clk,
    input logic                      i_rst_n,
    input logic                      i_stall,
    input logic                      i_flush,
    input rv_decode_pkg::xaddr_t     i_pc,
    input rv_decode_pkg::exec_ctrl_t i_ctrl
);

    // source selects drive one-hot muxes in execute
    a_op1_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot(i_ctrl.op1_src))
        else $error("op1 source select is not one-hot");

    a_op2_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot(i_ctrl.op2_src))
        else $error("op2 source select is not one-hot");

    a_res_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot(i_ctrl.res_src))
        else $error("result source select is not one-hot");

    // zero for lui, auipc, jumps and system
    a_alu_res_onehot0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_ctrl.alu_res))
        else $error("more than one alu result group selected");

    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stall && !i_flush) |=> $stable(i_pc))
        else $error("pc changed while the stage was stalled");

    a_flush_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !i_ctrl.reg_write)
        else $error("register write enabled right after a flush");

endmodule

//--- verification/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode;

    localparam int RESET_CYCLES = 16;
    localparam int N_LEGAL      = 600;
    localparam int N_ILLEGAL    = 300;
    localparam int N_CTRL       = 300;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_LEGAL + N_ILLEGAL + N_CTRL + 16;

    typedef struct packed {
        rv_decode_pkg::exec_ctrl_t ctrl;
        rv_decode_pkg::xdata_t     imm_i;
        rv_decode_pkg::xdata_t     imm_j;
        rv_decode_pkg::reg_idx_t   rd;
        rv_decode_pkg::reg_idx_t   rs1;
        rv_decode_pkg::reg_idx_t   rs2;
        rv_decode_pkg::funct3_t    funct3;
        logic                      supported;
        rv_decode_pkg::xaddr_t     pc_next;
    } expect_t;

    logic                      i_clk;
    logic                      i_rst_n;
    logic                      i_stall;
    logic                      i_flush;
    rv_decode_pkg::instr_t     i_instruction;
    rv_decode_pkg::xaddr_t     i_pc;
    logic                      i_branch_pred;
    logic                      i_is_compressed;
    rv_decode_pkg::xaddr_t     o_pc;
    rv_decode_pkg::xaddr_t     o_pc_next;
    logic                      o_branch_pred;
    rv_decode_pkg::reg_idx_t   o_rs1;
    rv_decode_pkg::reg_idx_t   o_rs2;
    rv_decode_pkg::reg_idx_t   o_rd;
    rv_decode_pkg::xdata_t     o_imm_i;
    rv_decode_pkg::xdata_t     o_imm_j;
    rv_decode_pkg::funct3_t    o_funct3;
    rv_decode_pkg::exec_ctrl_t o_ctrl;
    logic                      o_supported;

    // what the stage register should hold
    rv_decode_pkg::stage_t expected_stage;
    string                 test_name;

    rv_decode uut (.*);

    bind rv_decode rv_decode_assertions u_sva (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_pc    (o_pc),
        .i_ctrl  (o_ctrl)
    );

    initial i_clk = 1'b0;
    always #5 i_clk = ~i_clk;

    function automatic expect_t ref_decode(input rv_decode_pkg::instr_t w,
                                           input rv_decode_pkg::xaddr_t pc,
                                           input logic compressed);
        expect_t    e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;
        logic       ld, st, ari, arr, br, jl, jlr, lu, au, sy;
        logic       alu;
        logic       sub;
        logic       add;
        e   = '0;
        f3  = w[14:12];
        f7  = w[31:25];
        alt = (f7 == 7'h20);
        {ld, st, ari, arr, br, jl, jlr, lu, au, sy} = '0;
        if (w[1:0] == 2'b11)
        begin
            case (w[6:0])
                7'b0000011: ld  = 1'b1;
                7'b0100011: st  = 1'b1;
                7'b0010011: ari = 1'b1;
                7'b0110011: arr = 1'b1;
                7'b1100011: br  = 1'b1;
                7'b1101111: jl  = 1'b1;
                7'b1100111: jlr = 1'b1;
                7'b0110111: lu  = 1'b1;
                7'b0010111: au  = 1'b1;
                7'b1110011: sy  = 1'b1;
                default:    ;
            endcase
        end
        e.supported = (w == '0)
            | (ld & (f3 != 3'd3) & (f3 < 3'd6))
            | (st & (f3 < 3'd3))
            | (ari & ((f3 == 3'd1) ? (f7 == 7'h00) : ((f3 != 3'd5) | (f7 == 7'h00) | alt)))
            | (arr & ((f7 == 7'h00) | (alt & ((f3 == 3'd0) | (f3 == 3'd5)))))
            | (br & (f3[2:1] != 2'b01))
            | (jlr & (f3 == 3'd0))
            | (sy & (f3 == 3'd0) & (w[31:21] == 11'h000))
            | jl | lu | au;
        alu = ari | arr;
        sub = arr & (f3 == 3'd0) & alt;
        add = (alu & (f3 == 3'd0) & !sub) | ld | st;
        e.ctrl.op1_src = '{r: !(au | jl | lu), pc: au | jl, zero: lu};
        e.ctrl.op2_src = '{r: !(jl | jlr | ld | ari | lu | au | st),
                           i: jlr | ld | ari | lu | au | st, j: jl};
        e.ctrl.res_src = '{alu: !(ld | jl | jlr), memory: ld, pc_next: jl | jlr};
        e.ctrl.alu_res = '{cmp: br | (alu & (f3[2:1] == 2'b01)),
                           bits: alu & f3[2] & (f3 != 3'd5),
                           shift: alu & (f3[1:0] == 2'b01), arith: add | sub};
        e.ctrl.alu_ctrl = '{cmp_eq: br & (f3[2:1] == 2'b00),
                            cmp_lts: (alu & (f3 == 3'd2)) | (br & (f3[2:1] == 2'b10)),
                            cmp_ltu: (alu & (f3 == 3'd3)) | (br & (f3[2:1] == 2'b11)),
                            cmp_inversed: br & f3[0],
                            bits_and: alu & (f3 == 3'd7), bits_or: alu & (f3 == 3'd6),
                            bits_xor: alu & (f3 == 3'd4), arith_shl: alu & (f3 == 3'd1),
                            arith_shr: alu & (f3 == 3'd5), arith_sub: sub, arith_add: add,
                            shift_arithmetical: alu & (f3 == 3'd5) & alt};
        e.ctrl.reg_write   = ld | ari | arr | lu | au | jl | jlr;
        e.ctrl.inst_store  = st;
        e.ctrl.inst_branch = br;
        e.ctrl.inst_jal    = jl;
        e.ctrl.inst_jalr   = jlr;
        // I format unless upper or store
        e.imm_i = {{20{w[31]}}, w[31:20]};
        if (lu || au)
            e.imm_i = {w[31:12], 12'h000};
        else if (st)
            e.imm_i = {{20{w[31]}}, w[31:25], w[11:7]};
        e.imm_j = jl ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}
                     : {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.rd      = w[11:7];
        e.rs1     = lu ? 5'd0 : w[19:15];
        e.rs2     = w[24:20];
        e.funct3  = (w[1:0] == 2'b11) ? f3 : 3'd2;
        e.pc_next = pc + (compressed ? 32'd2 : 32'd4);
        return e;
    endfunction

    // grp: 0 load, 1 store, 2 op_imm, 3 op_reg, 4 branch, 5 jal, 6 jalr,
    // 7 lui, 8 auipc, 9 ecall/ebreak, 10 zero word
    function automatic rv_decode_pkg::instr_t make_legal(input int grp);
        rv_decode_pkg::instr_t w;
        logic [2:0]            f3;
        w  = $urandom;
        f3 = 3'($urandom);
        case (grp)
            0:       w[6:0] = 7'b0000011;
            1:       w[6:0] = 7'b0100011;
            2:       w[6:0] = 7'b0010011;
            3:       w[6:0] = 7'b0110011;
            4:       w[6:0] = 7'b1100011;
            5:       w[6:0] = 7'b1101111;
            6:       w[6:0] = 7'b1100111;
            7:       w[6:0] = 7'b0110111;
            8:       w[6:0] = 7'b0010111;
            9:       w = {11'h000, f3[0], 20'h00073};
            default: w = '0;
        endcase
        case (grp)
            0:       f3 = (f3 == 3'd3 || f3 > 3'd5) ? 3'd4 : f3;
            1:       f3 = f3 % 3'd3;
            4:       f3[2] = f3[2] | f3[1];
            6:       f3 = 3'd0;
            default: ;
        endcase
        if (grp < 7)
            w[14:12] = f3;
        // alternate funct7 only where the encoding allows it
        if ((grp == 2 && f3 == 3'd5) || (grp == 3 && (f3 == 3'd0 || f3 == 3'd5)))
            w[31:25] = {1'b0, w[30], 5'b00000};
        else if (grp == 3 || (grp == 2 && f3 == 3'd1))
            w[31:25] = 7'h00;
        return w;
    endfunction

    function automatic rv_decode_pkg::instr_t make_illegal(input int kind);
        rv_decode_pkg::instr_t w;
        w = $urandom;
        case (kind)
            0:       w = {1'b1, w[30:7], 7'b0110011};
            1:       w = {1'b1, w[30:15], 3'b001, w[11:7], 7'b0010011};
            2:       w = {w[31:15], (w[14:12] == 3'd0) ? 3'd1 : w[14:12], w[11:7], 7'b1110011};
            3:       w = 32'h30200073;
            4:       w = {1'b1, w[30:2], (w[1:0] == 2'b11) ? 2'b01 : w[1:0]};
            default: ;
        endcase
        return w;
    endfunction

    task automatic check_eq(input string field, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("FAIL %s %s: expected %h actual %h", test_name, field, expected, actual);
            $display("tests failed");
            $fatal(1, "decode output mismatch");
        end
    endtask

    task automatic drive(input rv_decode_pkg::instr_t w, input logic stall, input logic flush);
        @(posedge i_clk);
        #1;
        i_instruction   = w;
        i_pc            = $urandom;
        i_branch_pred   = 1'($urandom);
        i_is_compressed = 1'($urandom);
        i_stall         = stall;
        i_flush         = flush;
    endtask

    always @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
            expected_stage <= '0;
        else if (!i_stall)
            expected_stage <= '{instr: i_instruction, pc: i_pc,
                                branch_pred: i_branch_pred, is_compressed: i_is_compressed};
    end

    // outputs settle well before the falling edge
    initial
    begin
        expect_t e;
        @(posedge i_clk);
        forever
        begin
            @(negedge i_clk);
            e = ref_decode(expected_stage.instr, expected_stage.pc,
                           expected_stage.is_compressed);
            check_eq("ctrl", 64'(e.ctrl), 64'(o_ctrl));
            check_eq("imm_i", 64'(e.imm_i), 64'(o_imm_i));
            check_eq("imm_j", 64'(e.imm_j), 64'(o_imm_j));
            check_eq("rd", 64'(e.rd), 64'(o_rd));
            check_eq("rs1", 64'(e.rs1), 64'(o_rs1));
            check_eq("rs2", 64'(e.rs2), 64'(o_rs2));
            check_eq("funct3", 64'(e.funct3), 64'(o_funct3));
            check_eq("supported", 64'(e.supported), 64'(o_supported));
            check_eq("pc_next", 64'(e.pc_next), 64'(o_pc_next));
            check_eq("pc", 64'(expected_stage.pc), 64'(o_pc));
            check_eq("branch_pred", 64'(expected_stage.branch_pred), 64'(o_branch_pred));
        end
    end

    initial
    begin
        void'($urandom(24007));
        test_name       = "reset";
        i_rst_n         = 1'b0;
        i_stall         = 1'b0;
        i_flush         = 1'b0;
        i_instruction   = 32'hffff_ffff;
        i_pc            = 32'h0000_1000;
        i_branch_pred   = 1'b1;
        i_is_compressed = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        test_name = "legal";
        repeat (N_LEGAL) drive(make_legal(int'($urandom % 11)), 1'b0, 1'b0);
        test_name = "illegal";
        repeat (N_ILLEGAL) drive(make_illegal(int'($urandom % 6)), 1'b0, 1'b0);
        test_name = "stall_flush";
        repeat (N_CTRL)
            drive(make_legal(int'($urandom % 11)), ($urandom % 3) == 0, ($urandom % 8) == 0);
        test_name = "long_stall";
        repeat (6) drive(make_legal(int'($urandom % 11)), 1'b1, 1'b0);
        test_name = "flush";
        repeat (3) drive(make_legal(int'($urandom % 11)), 1'b0, 1'b1);
        drive('0, 1'b0, 1'b0);
        @(posedge i_clk);
        @(negedge i_clk);
        #1;
        $display("all tests passed");
        $finish;
    end

    initial
    begin
        #(TOTAL_CYCLES * 10 + 1000);
        $display("timeout: the stimulus did not finish within the expected run time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog/decode_latch.sv
`timescale 1ns/1ps

`include "rv_decode_params.svh"

module decode_latch
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  rv_decode_pkg::stage_t i_stage,
    output rv_decode_pkg::stage_t o_stage,
    output rv_decode_pkg::xaddr_t o_pc_next
);

    rv_decode_pkg::stage_t stage_q;
    rv_decode_pkg::xaddr_t pc_step;

    // reset and flush win over stall
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_flush)
        begin
            stage_q <= '0;
        end
        else if (!i_stall)
        begin
            stage_q <= i_stage;
        end
    end

    assign o_stage = stage_q;

    // step is 2 for a compressed word, 4 otherwise
    assign pc_step = {
        {(`RV_IADDR_BITS-3){1'b0}},
        !stage_q.is_compressed,
        stage_q.is_compressed,
        1'b0
    };

    // sequential fetch address, used as the link value of jal/jalr
    assign o_pc_next = stage_q.pc + pc_step;

endmodule

//--- verilog/exec_ctrl_gen.sv
`timescale 1ns/1ps

module exec_ctrl_gen
(
    input  rv_decode_pkg::inst_class_t i_class,
    output rv_decode_pkg::exec_ctrl_t  o_ctrl,
    output rv_decode_pkg::funct3_t     o_funct3
);

    logic alu_op;
    logic f3_add;
    logic f3_sll;
    logic f3_slt;
    logic f3_sltu;
    logic f3_xor;
    logic f3_sr;
    logic f3_or;
    logic f3_and;
    logic is_sub;
    logic is_add;

    // immediate and register arithmetic share the funct3 map
    assign alu_op  = i_class.op_imm | i_class.op_reg;
    assign f3_add  = (i_class.funct3 == 3'b000);
    assign f3_sll  = (i_class.funct3 == 3'b001);
    assign f3_slt  = (i_class.funct3 == 3'b010);
    assign f3_sltu = (i_class.funct3 == 3'b011);
    assign f3_xor  = (i_class.funct3 == 3'b100);
    assign f3_sr   = (i_class.funct3 == 3'b101);
    assign f3_or   = (i_class.funct3 == 3'b110);
    assign f3_and  = (i_class.funct3 == 3'b111);

    // addi has no sub form, its upper bits are immediate
    assign is_sub = i_class.op_reg & f3_add & i_class.alt;
    assign is_add = (alu_op & f3_add & !is_sub) | i_class.load | i_class.store;

    assign o_ctrl.op1_src.pc   = i_class.auipc | i_class.jal;
    assign o_ctrl.op1_src.zero = i_class.lui;
    assign o_ctrl.op1_src.r    = !(i_class.auipc | i_class.jal | i_class.lui);

    assign o_ctrl.op2_src.j = i_class.jal;
    assign o_ctrl.op2_src.i = i_class.jalr | i_class.load | i_class.op_imm
                            | i_class.lui | i_class.auipc | i_class.store;
    assign o_ctrl.op2_src.r = !(o_ctrl.op2_src.j | o_ctrl.op2_src.i);

    assign o_ctrl.res_src.memory  = i_class.load;
    assign o_ctrl.res_src.pc_next = i_class.jal | i_class.jalr;
    assign o_ctrl.res_src.alu     = !(i_class.load | i_class.jal | i_class.jalr);

    assign o_ctrl.alu_res.cmp   = i_class.branch | (alu_op & (f3_slt | f3_sltu));
    assign o_ctrl.alu_res.bits  = alu_op & (f3_xor | f3_or | f3_and);
    assign o_ctrl.alu_res.shift = alu_op & (f3_sll | f3_sr);
    assign o_ctrl.alu_res.arith = is_add | is_sub;

    // beq/bne, blt/bge, bltu/bgeu pair up on funct3[2:1]
    assign o_ctrl.alu_ctrl.cmp_eq       = i_class.branch & (i_class.funct3[2:1] == 2'b00);
    assign o_ctrl.alu_ctrl.cmp_lts      = (alu_op & f3_slt)
                                        | (i_class.branch & (i_class.funct3[2:1] == 2'b10));
    assign o_ctrl.alu_ctrl.cmp_ltu      = (alu_op & f3_sltu)
                                        | (i_class.branch & (i_class.funct3[2:1] == 2'b11));
    // odd funct3 branches take the negated compare
    assign o_ctrl.alu_ctrl.cmp_inversed = i_class.branch & i_class.funct3[0];
    assign o_ctrl.alu_ctrl.bits_and     = alu_op & f3_and;
    assign o_ctrl.alu_ctrl.bits_or      = alu_op & f3_or;
    assign o_ctrl.alu_ctrl.bits_xor     = alu_op & f3_xor;
    assign o_ctrl.alu_ctrl.arith_shl    = alu_op & f3_sll;
    assign o_ctrl.alu_ctrl.arith_shr    = alu_op & f3_sr;
    assign o_ctrl.alu_ctrl.arith_sub    = is_sub;
    assign o_ctrl.alu_ctrl.arith_add    = is_add;
    assign o_ctrl.alu_ctrl.shift_arithmetical = alu_op & f3_sr & i_class.alt;

    // system instructions never write the register file
    assign o_ctrl.reg_write = i_class.load | i_class.op_imm | i_class.op_reg
                            | i_class.lui | i_class.auipc | i_class.jal | i_class.jalr;

    assign o_ctrl.inst_store  = i_class.store;
    assign o_ctrl.inst_branch = i_class.branch;
    assign o_ctrl.inst_jal    = i_class.jal;
    assign o_ctrl.inst_jalr   = i_class.jalr;

    // word width for the memory unit when not a full encoding
    assign o_funct3 = i_class.full ? i_class.funct3 : 3'b010;

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
(
    input  rv_decode_pkg::instr_t      i_instr,
    input  rv_decode_pkg::inst_class_t i_class,
    output rv_decode_pkg::xdata_t      o_imm_i,
    output rv_decode_pkg::xdata_t      o_imm_j
);

    rv_decode_pkg::xdata_t imm_i;
    rv_decode_pkg::xdata_t imm_s;
    rv_decode_pkg::xdata_t imm_u;
    rv_decode_pkg::xdata_t imm_b;
    rv_decode_pkg::xdata_t imm_j;

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_u = {i_instr[31:12], 12'b0};

    // branch and jump offsets are half-word aligned
    assign imm_b = {
        {20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0
    };
    assign imm_j = {
        {12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0
    };

    // operand-2 immediate
    assign o_imm_i = (i_class.lui | i_class.auipc) ? imm_u :
                     i_class.store                 ? imm_s :
                                                     imm_i;

    // target offset for the branch unit
    assign o_imm_j = i_class.jal ? imm_j : imm_b;

endmodule

//--- verilog/instr_classifier.sv
`timescale 1ns/1ps

`include "rv_decode_params.svh"

module instr_classifier
(
    input  rv_decode_pkg::instr_t      i_instr,
    output rv_decode_pkg::inst_class_t o_class,
    output rv_decode_pkg::reg_fields_t o_regs,
    output logic                       o_supported
);

    logic [4:0]             opc;
    logic                   full;
    rv_decode_pkg::funct3_t funct3;
    logic [6:0]             funct7;
    logic [11:0]            funct12;
    logic                   f7_base;
    logic                   f7_alt;
    logic                   word_zero;

    logic                   load_ok;
    logic                   store_ok;
    logic                   op_imm_ok;
    logic                   op_reg_ok;
    logic                   branch_ok;
    logic                   jalr_ok;
    logic                   system_ok;

    assign opc     = i_instr[6:2];
    assign full    = (i_instr[1:0] == `RV_OPC_FULL);
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign funct12 = i_instr[31:20];
    assign f7_base = (funct7 == `RV_F7_BASE);
    assign f7_alt  = (funct7 == `RV_F7_ALT);

    // all-zero word counts as a legal bubble
    assign word_zero = (i_instr == '0);

    // instruction groups
    assign o_class.load   = full & (opc == `RV_OPC_LD);
    assign o_class.store  = full & (opc == `RV_OPC_STR);
    assign o_class.op_imm = full & (opc == `RV_OPC_ARI);
    assign o_class.op_reg = full & (opc == `RV_OPC_ARR);
    assign o_class.branch = full & (opc == `RV_OPC_B);
    assign o_class.jal    = full & (opc == `RV_OPC_JAL);
    assign o_class.jalr   = full & (opc == `RV_OPC_JALR);
    assign o_class.lui    = full & (opc == `RV_OPC_LUI);
    assign o_class.auipc  = full & (opc == `RV_OPC_AUI);
    assign o_class.system = full & (opc == `RV_OPC_SYS);
    assign o_class.alt    = f7_alt;
    assign o_class.funct3 = funct3;
    assign o_class.full   = full;

    // lb, lh, lw, lbu, lhu
    always_comb
    begin
        case (funct3)
            3'b000, 3'b001, 3'b010, 3'b100, 3'b101: load_ok = 1'b1;
            default:                                load_ok = 1'b0;
        endcase
    end

    // sb, sh, sw
    assign store_ok = !funct3[2] & (funct3[1:0] != 2'b11);

    // shift amounts only allow the base form, srai also the alternate
    always_comb
    begin
        case (funct3)
            3'b001:  op_imm_ok = f7_base;
            3'b101:  op_imm_ok = f7_base | f7_alt;
            default: op_imm_ok = 1'b1;
        endcase
    end

    // alternate funct7 only for sub and sra
    always_comb
    begin
        case (funct3)
            3'b000, 3'b101: op_reg_ok = f7_base | f7_alt;
            default:        op_reg_ok = f7_base;
        endcase
    end

    // funct3 010 and 011 are holes in the branch space
    assign branch_ok = (funct3[2:1] != 2'b01);
    assign jalr_ok   = (funct3 == 3'b000);

    // ecall and ebreak only; csr and mret words fall out here
    assign system_ok = (funct3 == 3'b000)
                     & ((funct12 == `RV_F12_ECALL) | (funct12 == `RV_F12_EBREAK));

    assign o_supported = word_zero
                       | (o_class.load   & load_ok)
                       | (o_class.store  & store_ok)
                       | (o_class.op_imm & op_imm_ok)
                       | (o_class.op_reg & op_reg_ok)
                       | (o_class.branch & branch_ok)
                       | (o_class.jalr   & jalr_ok)
                       | (o_class.system & system_ok)
                       | o_class.jal
                       | o_class.lui
                       | o_class.auipc;

    assign o_regs.rd  = i_instr[11:7];
    // lui adds its immediate to x0
    assign o_regs.rs1 = o_class.lui ? '0 : i_instr[19:15];
    assign o_regs.rs2 = i_instr[24:20];

endmodule

//--- verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_stall,
    input  logic                       i_flush,
    input  rv_decode_pkg::instr_t      i_instruction,
    input  rv_decode_pkg::xaddr_t      i_pc,
    input  logic                       i_branch_pred,
    input  logic                       i_is_compressed,
    output rv_decode_pkg::xaddr_t      o_pc,
    output rv_decode_pkg::xaddr_t      o_pc_next,
    output logic                       o_branch_pred,
    output rv_decode_pkg::reg_idx_t    o_rs1,
    output rv_decode_pkg::reg_idx_t    o_rs2,
    output rv_decode_pkg::reg_idx_t    o_rd,
    output rv_decode_pkg::xdata_t      o_imm_i,
    output rv_decode_pkg::xdata_t      o_imm_j,
    output rv_decode_pkg::funct3_t     o_funct3,
    output rv_decode_pkg::exec_ctrl_t  o_ctrl,
    output logic                       o_supported
);

    rv_decode_pkg::stage_t      stage_in;
    rv_decode_pkg::stage_t      stage;
    rv_decode_pkg::inst_class_t inst_class;
    rv_decode_pkg::reg_fields_t regs;

    assign stage_in.instr         = i_instruction;
    assign stage_in.pc            = i_pc;
    assign stage_in.branch_pred   = i_branch_pred;
    assign stage_in.is_compressed = i_is_compressed;

    decode_latch u_latch (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stall   (i_stall),
        .i_flush   (i_flush),
        .i_stage   (stage_in),
        .o_stage   (stage),
        .o_pc_next (o_pc_next)
    );

    instr_classifier u_classifier (
        .i_instr     (stage.instr),
        .o_class     (inst_class),
        .o_regs      (regs),
        .o_supported (o_supported)
    );

    imm_gen u_imm (
        .i_instr (stage.instr),
        .i_class (inst_class),
        .o_imm_i (o_imm_i),
        .o_imm_j (o_imm_j)
    );

    exec_ctrl_gen u_exec (
        .i_class  (inst_class),
        .o_ctrl   (o_ctrl),
        .o_funct3 (o_funct3)
    );

    assign o_pc          = stage.pc;
    assign o_branch_pred = stage.branch_pred;
    assign o_rs1         = regs.rs1;
    assign o_rs2         = regs.rs2;
    assign o_rd          = regs.rd;

endmodule

//--- verilog/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// instruction and immediate width
`define RV_XLEN             32
// program counter width
`define RV_IADDR_BITS       32
`define RV_REG_IDX_BITS     5

// major opcode, bits [6:2] of the word
`define RV_OPC_LD           5'b00000
`define RV_OPC_STR          5'b01000
`define RV_OPC_ARI          5'b00100
`define RV_OPC_ARR          5'b01100
`define RV_OPC_LUI          5'b01101
`define RV_OPC_AUI          5'b00101
`define RV_OPC_B            5'b11000
`define RV_OPC_JAL          5'b11011
`define RV_OPC_JALR         5'b11001
`define RV_OPC_SYS          5'b11100

// bits [1:0] of a full 32-bit encoding
`define RV_OPC_FULL         2'b11

// funct7 forms
`define RV_F7_BASE          7'b0000000
`define RV_F7_ALT           7'b0100000

// funct12 of the system instructions we accept
`define RV_F12_ECALL        12'h000
`define RV_F12_EBREAK       12'h001

`endif

//--- verilog/rv_decode_pkg.sv
`include "rv_decode_params.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]         instr_t;
    typedef logic [`RV_IADDR_BITS-1:0]   xaddr_t;
    typedef logic [`RV_XLEN-1:0]         xdata_t;
    typedef logic [`RV_REG_IDX_BITS-1:0] reg_idx_t;
    typedef logic [2:0]                  funct3_t;

    // one group flag per major opcode, plus the raw bits the ALU decode needs
    typedef struct packed {
        logic    load;
        logic    store;
        logic    op_imm;
        logic    op_reg;
        logic    branch;
        logic    jal;
        logic    jalr;
        logic    lui;
        logic    auipc;
        logic    system;
        logic    alt;
        funct3_t funct3;
        logic    full;
    } inst_class_t;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } reg_fields_t;

    typedef struct packed {
        logic r;
        logic pc;
        logic zero;
    } op1_src_t;

    typedef struct packed {
        logic r;
        logic i;
        logic j;
    } op2_src_t;

    typedef struct packed {
        logic alu;
        logic memory;
        logic pc_next;
    } res_src_t;

    // alu result group
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    typedef struct packed {
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed {
        op1_src_t  op1_src;
        op2_src_t  op2_src;
        res_src_t  res_src;
        alu_res_t  alu_res;
        alu_ctrl_t alu_ctrl;
        logic      reg_write;
        logic      inst_store;
        logic      inst_branch;
        logic      inst_jal;
        logic      inst_jalr;
    } exec_ctrl_t;

    // contents of the decode pipeline register
    typedef struct packed {
        instr_t instr;
        xaddr_t pc;
        logic   branch_pred;
        logic   is_compressed;
    } stage_t;

endpackage
